/* hw/fir_cfg_pkg.sv */
/*
 * FIR output filter configuration
 * Sample and coefficient widths, derived pre-adder, product and
 * accumulator sizes, and the sequencer state encoding
 */
package fir_cfg_pkg;

    localparam int SAMPLE_W = 9;        // Default audio sample width
    localparam int COEFF_W  = 9;        // Signed coefficient width
    localparam int GUARD_W  = 3;        // Accumulator headroom over one product

    // Pre-adder needs one bit over the sample
    function automatic int sum_width(int sample_w);
        return sample_w + 1;
    endfunction

    function automatic int prod_width(int sample_w);
        return sum_width(sample_w) + COEFF_W;   // Folded sum times coefficient
    endfunction

    function automatic int acc_width(int sample_w);
        return prod_width(sample_w) + GUARD_W;
    endfunction

    localparam int SUM_W  = sum_width(SAMPLE_W);    // 10 with defaults
    localparam int PROD_W = SUM_W + COEFF_W;        // 19 with defaults
    localparam int ACC_W  = PROD_W + GUARD_W;       // 22 with defaults

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,     // Waiting for a strobe
        SEQ_BUSY    = 2'd1,     // Walking tap pairs
        SEQ_RELEASE = 2'd2      // Accumulator to output
    } seq_state_t;

endpackage

/* hw/fir_coeff_pkg.sv */
/*
 * FIR coefficient ROM
 * Stage count, centre tap index and the 37 distinct coefficients
 * of the 73-tap symmetric low-pass, with a lookup by tap index
 */
package fir_coeff_pkg;

    import fir_cfg_pkg::*;

    localparam int FIR_STAGES = 73;                 // Delay line length
    localparam int FIR_HALF   = (FIR_STAGES - 1) / 2; // Centre tap, 36
    localparam int TAP_IDX_W  = 7;                  // Covers 0..72

    // Outer taps first, centre tap last
    localparam logic signed [COEFF_W-1:0] FIR_COEFF [FIR_HALF+1] = '{
         9'sd0,   -9'sd1,   -9'sd1,   -9'sd2,   -9'sd3,
        -9'sd3,   -9'sd4,   -9'sd4,   -9'sd3,   -9'sd1,
         9'sd1,    9'sd3,    9'sd7,    9'sd10,   9'sd12,
         9'sd13,   9'sd12,   9'sd9,    9'sd3,   -9'sd5,
        -9'sd14,  -9'sd24,  -9'sd33,  -9'sd40,  -9'sd43,
        -9'sd39,  -9'sd29,  -9'sd12,   9'sd13,   9'sd44,
         9'sd80,   9'sd119,  9'sd157,  9'sd192,  9'sd222,
         9'sd243,  9'sd255
    };

    // Coefficient of any tap 0..72, upper half mirrors the lower half
    function automatic logic signed [COEFF_W-1:0] coeff_at(
        input logic [TAP_IDX_W-1:0] idx
    );
        int unsigned pos;
        pos = idx;
        if (pos > FIR_HALF) begin
            pos = FIR_STAGES - 1 - pos;     // Mirror onto the stored half
        end
        return FIR_COEFF[pos];
    endfunction

endpackage

/* hw/tap_bus_if.sv */
/*
 * Tap walk bus
 * Forward and mirrored tap indices with step and centre flags,
 * driven by the tap counter and read by the delay line and MAC
 */
`timescale 1ns/100ps

interface tap_bus_if import fir_coeff_pkg::*; ();

    logic [TAP_IDX_W-1:0] fwd_idx;     // Outer-to-centre tap
    logic [TAP_IDX_W-1:0] rev_idx;     // Mirrored partner tap
    logic                 last_pair;   // Centre tap, counted once
    logic                 step;        // Pair valid this cycle

    modport counter (
        output fwd_idx,
        output rev_idx,
        output last_pair,
        output step
    );

    modport line (
        input fwd_idx,
        input rev_idx
    );

    // MAC also needs the forward index for the coefficient lookup
    modport mac (
        input step,
        input last_pair,
        input fwd_idx
    );

endinterface

/* hw/fir_sequencer.sv */
/*
 * FIR sequencer
 * Registers the sample strobe, finds its rising edge, accepts it
 * when idle or flags overrun, then walks busy and release
 */
`timescale 1ns/100ps

module fir_sequencer import fir_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       sample,         // Strobe level from the synth core
    input  logic       last_pair,      // Centre tap reached
    output logic       accept,         // Shift in din, start a walk
    output logic       busy,
    output logic       release_out,    // One-cycle copy to dout
    output logic       overrun,        // Strobe dropped
    output seq_state_t state
);

    logic sample_q;     // Input register for the strobe
    logic sample_qq;    // Previous strobe level
    logic edge_q;       // Rising edge seen

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_q  <= 1'b0;
            sample_qq <= 1'b0;
            edge_q    <= 1'b0;
        end else begin
            sample_q  <= sample;
            sample_qq <= sample_q;
            edge_q    <= sample_q & ~sample_qq;    // Pulse one cycle after the edge
        end
    end

    // Accept or drop is decided in the same cycle
    assign accept  = edge_q && (state == SEQ_IDLE);
    assign overrun = edge_q && (state != SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        state <= SEQ_BUSY;
                    end
                end
                SEQ_BUSY: begin
                    if (last_pair) begin
                        state <= SEQ_RELEASE;  // 37 pairs done
                    end
                end
                SEQ_RELEASE: begin
                    state <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;         // Unused encoding
                end
            endcase
        end
    end

    assign busy        = (state != SEQ_IDLE);      // Walk plus release, 38 cycles
    assign release_out = (state == SEQ_RELEASE);

endmodule

/* hw/tap_counter.sv */
/*
 * Tap counter
 * Forward and mirrored tap indices walking toward the centre,
 * one folded pair per busy cycle
 */
`timescale 1ns/100ps

module tap_counter import fir_coeff_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic accept,           // Start a new walk
    input  logic busy,             // Accumulate cycle
    tap_bus_if.counter tap
);

    localparam logic [TAP_IDX_W-1:0] REV_START = TAP_IDX_W'(FIR_STAGES - 1);
    localparam logic [TAP_IDX_W-1:0] CENTRE    = TAP_IDX_W'(FIR_HALF);

    logic [TAP_IDX_W-1:0] fwd_q;
    logic [TAP_IDX_W-1:0] rev_q;
    logic                 at_centre;

    assign at_centre = (fwd_q == CENTRE);

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_q <= '0;
            rev_q <= REV_START;
        end else if (accept) begin
            fwd_q <= '0;               // Newest sample
            rev_q <= REV_START;        // Oldest sample
        end else if (busy && !at_centre) begin
            fwd_q <= fwd_q + 1'b1;
            rev_q <= rev_q - 1'b1;
        end
    end

    assign tap.fwd_idx   = fwd_q;
    assign tap.rev_idx   = rev_q;
    assign tap.step      = busy;                   // Pair lines up with the accumulate
    assign tap.last_pair = busy && at_centre;

endmodule

/* hw/sample_delay_line.sv */
/*
 * Sample delay line
 * 73-entry signed shift register with two combinational read
 * ports for the forward and mirrored taps
 */
`timescale 1ns/100ps

module sample_delay_line
    import fir_cfg_pkg::*;
    import fir_coeff_pkg::*;
#(
    parameter int DATA_W = SAMPLE_W
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     accept,       // Shift in a new sample
    input  logic signed [DATA_W-1:0] din,
    tap_bus_if.line                  tap,
    output logic signed [DATA_W-1:0] fwd_sample,
    output logic signed [DATA_W-1:0] rev_sample
);

    logic signed [DATA_W-1:0] taps [FIR_STAGES];  // Entry 0 is the newest

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FIR_STAGES; i++) begin
                taps[i] <= '0;         // Known history after reset
            end
        end else if (accept) begin
            taps[0] <= din;
            for (int i = 1; i < FIR_STAGES; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // Folded pair read
    assign fwd_sample = taps[tap.fwd_idx];
    assign rev_sample = taps[tap.rev_idx];

endmodule

/* hw/symmetric_mac.sv */
/*
 * Symmetric MAC
 * Pre-adds the folded tap pair, multiplies by the shared
 * coefficient and accumulates, then registers the result
 */
`timescale 1ns/100ps

module symmetric_mac
    import fir_cfg_pkg::*;
    import fir_coeff_pkg::*;
#(
    parameter int DATA_W = SAMPLE_W
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                accept,        // Clear for a new walk
    input  logic                                release_in,    // Copy out
    input  logic signed [DATA_W-1:0]            fwd_sample,
    input  logic signed [DATA_W-1:0]            rev_sample,
    tap_bus_if.mac                              tap,
    output logic signed [acc_width(DATA_W)-1:0] dout,
    output logic                                dout_valid
);

    localparam int PRE_W = sum_width(DATA_W);
    localparam int MUL_W = prod_width(DATA_W);
    localparam int OUT_W = acc_width(DATA_W);

    logic signed [PRE_W-1:0]   pre_sum;
    logic signed [COEFF_W-1:0] coeff;
    logic signed [MUL_W-1:0]   product;
    logic signed [OUT_W-1:0]   acc;

    always_comb begin
        pre_sum = fwd_sample;                      // Sign extended
        if (!tap.last_pair) begin
            pre_sum = pre_sum + rev_sample;        // Centre tap counted once
        end
        coeff   = coeff_at(tap.fwd_idx);
        product = pre_sum * coeff;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (accept) begin
            acc <= '0;
        end else if (tap.step) begin
            acc <= acc + product;
        end
    end

    // Output holds until the next release
    always_ff @(posedge clk) begin
        if (rst) begin
            dout       <= '0;
            dout_valid <= 1'b0;
        end else begin
            if (release_in) begin
                dout <= acc;
            end
            dout_valid <= release_in;              // Pulse with the new dout
        end
    end

endmodule

/* hw/fir_filter_top.sv */
/*
 * FIR output filter
 * 73-tap symmetric low-pass on the audio path, one folded pair
 * per clock, strobe in and valid pulse out
 */
`timescale 1ns/100ps

module fir_filter_top import fir_cfg_pkg::*; #(
    parameter int DATA_W = SAMPLE_W
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                sample,        // Strobe level
    input  logic signed [DATA_W-1:0]            din,
    output logic signed [acc_width(DATA_W)-1:0] dout,
    output logic                                dout_valid,
    output logic                                overrun,
    output logic                                busy
);

    logic                     accept;
    logic                     seq_release;
    seq_state_t               seq_state;
    logic signed [DATA_W-1:0] fwd_sample;
    logic signed [DATA_W-1:0] rev_sample;

    tap_bus_if tap ();

    fir_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .sample      (sample),
        .last_pair   (tap.last_pair),
        .accept      (accept),
        .busy        (busy),
        .release_out (seq_release),
        .overrun     (overrun),
        .state       (seq_state)
    );

    // Counter steps only in the walk, not in release
    tap_counter u_cnt (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .busy   (seq_state == SEQ_BUSY),
        .tap    (tap.counter)
    );

    sample_delay_line #(.DATA_W(DATA_W)) u_line (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .din        (din),
        .tap        (tap.line),
        .fwd_sample (fwd_sample),
        .rev_sample (rev_sample)
    );

    symmetric_mac #(.DATA_W(DATA_W)) u_mac (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .release_in (seq_release),
        .fwd_sample (fwd_sample),
        .rev_sample (rev_sample),
        .tap        (tap.mac),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

/* testbench/fir_filter_checker.sv */
/*
 * FIR filter protocol checker
 * Bound to the filter top, watches the valid pulse, overrun
 * and the length of each busy window
 */
`timescale 1ns/100ps

module fir_filter_checker (
    input logic clk,
    input logic rst,
    input logic sample,
    input logic dout_valid,
    input logic overrun,
    input logic busy
);

    localparam int BUSY_LEN = 38;          // 37 pairs plus release

    int unsigned fail_count = 0;
    int unsigned busy_run;                 // Busy cycles seen so far in this window

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_run <= 0;
        end else if (busy) begin
            busy_run <= busy_run + 1;
        end else begin
            busy_run <= 0;
        end
    end

    valid_single: assert property (@(posedge clk) disable iff (rst)
        dout_valid |=> !dout_valid)
        else begin
            $error("dout_valid high in two consecutive cycles");
            fail_count++;
        end

    // Overrun traces back to a strobe edge two samples earlier, inside a busy window
    overrun_in_busy: assert property (@(posedge clk) disable iff (rst)
        overrun |-> (busy && $past(sample, 2) && !$past(sample, 3)))
        else begin
            $error("overrun raised without a strobe edge during busy");
            fail_count++;
        end

    // Window closes at exactly BUSY_LEN cycles
    busy_not_long: assert property (@(posedge clk) disable iff (rst)
        busy |-> (busy_run < BUSY_LEN))
        else begin
            $error("busy window longer than %0d cycles", BUSY_LEN);
            fail_count++;
        end

    busy_not_short: assert property (@(posedge clk) disable iff (rst)
        (!busy && busy_run != 0) |-> (busy_run == BUSY_LEN))
        else begin
            $error("busy window ended after %0d cycles", busy_run);
            fail_count++;
        end

    valid_when_idle: assert property (@(posedge clk) disable iff (rst)
        dout_valid |-> !busy)
        else begin
            $error("dout_valid during busy");
            fail_count++;
        end

endmodule

bind fir_filter_top fir_filter_checker u_chk (
    .clk        (clk),
    .rst        (rst),
    .sample     (sample),
    .dout_valid (dout_valid),
    .overrun    (overrun),
    .busy       (busy)
);

/* testbench/fir_filter_tb.sv */
/*
 * FIR output filter testbench
 * LFSR driven strobes checked against a reference convolution over
 * its own 73-entry history, with latency, overrun and timeout checks
 */
`timescale 1ns/100ps

module fir_filter_tb
    import fir_cfg_pkg::*;
    import fir_coeff_pkg::*;
();

    localparam int DW          = SAMPLE_W;
    localparam int LATENCY     = 40;                  // Strobe edge to dout_valid
    localparam int MAX_GAP     = 64;                  // Longest strobe spacing
    localparam int N_IMPULSE   = FIR_STAGES;
    localparam int N_RANDOM    = 200;
    localparam int N_EXTREME   = 2 * (FIR_STAGES + 1);
    localparam int N_OVERRUN   = 30;
    localparam int CYCLE_LIMIT = (N_IMPULSE + N_RANDOM + N_EXTREME + N_OVERRUN) * MAX_GAP + 1000;
    localparam logic signed [DW-1:0] S_MIN = {1'b1, {(DW-1){1'b0}}};
    localparam logic signed [DW-1:0] S_MAX = {1'b0, {(DW-1){1'b1}}};

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    sample;
    logic signed [DW-1:0]    din;
    logic signed [ACC_W-1:0] dout;
    logic                    dout_valid;
    logic                    overrun;
    logic                    busy;

    logic [31:0]          lfsr = 32'h67ae2b69;
    logic signed [DW-1:0] hist [FIR_STAGES];      // Entry 0 is the newest
    int                   cycles = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   test_errors = 0;
    int unsigned          assert_fails;

    fir_filter_top #(.DATA_W(DW)) uut (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .din        (din),
        .dout       (dout),
        .dout_valid (dout_valid),
        .overrun    (overrun),
        .busy       (busy)
    );

    always #4 clk = ~clk;                         // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic void push_history(input logic signed [DW-1:0] x);
        for (int i = FIR_STAGES - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = x;
    endfunction

    // Full convolution, mirrored taps share a coefficient
    function automatic logic signed [ACC_W-1:0] model_output();
        longint acc;
        acc = 0;
        for (int k = 0; k < FIR_HALF; k++) begin
            acc += longint'(FIR_COEFF[k]) *
                   (longint'(hist[k]) + longint'(hist[FIR_STAGES-1-k]));
        end
        acc += longint'(FIR_COEFF[FIR_HALF]) * longint'(hist[FIR_HALF]);   // Centre once
        return ACC_W'(acc);
    endfunction

    task automatic check_dout(input logic signed [ACC_W-1:0] got,
                              input logic signed [ACC_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0t ns: dout is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0t ns: dout_valid after %0d edges, expected %0d",
                     $time, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // One strobe up to its output, drop_at >= 0 adds a strobe that must be dropped
    task automatic run_strobe(input logic signed [DW-1:0] x, input int spacing,
                              input int drop_at);
        logic signed [ACC_W-1:0] exp;
        int                      n;
        push_history(x);
        exp    = model_output();
        sample = 1'b1;
        din    = x;
        @(posedge clk);                           // Edge 0, strobe sampled high
        #1;
        sample = 1'b0;
        n      = 0;
        while (!dout_valid && n < MAX_GAP) begin
            if (n == drop_at) begin
                sample = 1'b1;                    // Lands in the busy window
                din    = DW'(next_bits(DW));
            end
            @(posedge clk);
            #1;
            sample = 1'b0;
            n++;
            check_flag(overrun, (drop_at >= 0) && (n == drop_at + 2), "overrun");
            check_flag(busy, (n >= 2) && (n < LATENCY), "busy");   // Walk plus release
        end
        if (!dout_valid) begin
            errors++;
            test_errors++;
            $display("No dout_valid within %0d cycles of the strobe, at %0t ns",
                     MAX_GAP, $time);
        end else begin
            check_latency(n, LATENCY);
            check_dout(dout, exp);
        end
        while (n < spacing - 1) begin             // Quiet gap until the next strobe
            @(posedge clk);
            #1;
            n++;
            check_flag(dout_valid, 1'b0, "dout_valid");
            check_flag(overrun, 1'b0, "overrun");
        end
    endtask

    initial begin
        rst    = 1'b1;
        sample = 1'b0;
        din    = '0;
        for (int i = 0; i < FIR_STAGES; i++) begin
            hist[i] = '0;                         // Matches the cleared line
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (8) begin
            @(posedge clk);
            #1;
            check_dout(dout, '0);
            check_flag(dout_valid, 1'b0, "dout_valid");
            check_flag(overrun, 1'b0, "overrun");
            check_flag(busy, 1'b0, "busy");
        end
        report_test("reset");

        run_strobe(DW'(1), 48, -1);               // Unit impulse, then zeros
        for (int k = 1; k < N_IMPULSE; k++) begin
            run_strobe('0, 48, -1);
        end
        report_test("impulse");

        for (int k = 0; k < N_RANDOM; k++) begin
            run_strobe(DW'(next_bits(DW)), 42 + int'(next_bits(4)), -1);
        end
        report_test("random");

        for (int k = 0; k < N_EXTREME; k++) begin
            run_strobe((k <= FIR_STAGES) ? S_MIN : S_MAX, 42, -1);
        end
        report_test("extremes");

        for (int k = 0; k < N_OVERRUN; k++) begin
            run_strobe(DW'(next_bits(DW)), 42, 4 + int'(next_bits(5)));
        end
        report_test("overrun");

        assert_fails = uut.u_chk.fail_count;
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
hw/fir_cfg_pkg.sv
hw/fir_coeff_pkg.sv
hw/tap_bus_if.sv
hw/fir_sequencer.sv
hw/tap_counter.sv
hw/sample_delay_line.sv
hw/symmetric_mac.sv
hw/fir_filter_top.sv
testbench/fir_filter_checker.sv
testbench/fir_filter_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FIR filter testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module fir_filter_tb \
    --Mdir "$OBJ" -o fir_sim \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Keep running past assertion errors so the testbench can summarize
"./$OBJ/fir_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Run passed"
    exit 0
else
    echo "Run failed, see $LOG"
    exit 1
fi
